// File: rtl/blkenc_pkg.sv
// Block encrypt package with widths, shared data types and AES byte helpers

package blkenc_pkg;

  // ----------------------------------------
  // Widths and depths
  // ----------------------------------------
  localparam int BlkLen       = 128;
  localparam int KeyLen       = 256;
  localparam int CmdLen       = 3;
  localparam int IdLen        = 4;
  localparam int NumRounds    = 14;
  localparam int TagFifoDepth = 2;

  // Tag FIFO pointer and occupancy widths
  localparam int TagPtrW = (TagFifoDepth > 1) ? $clog2(TagFifoDepth) : 1;
  localparam int TagCntW = $clog2(TagFifoDepth + 1);

  // ----------------------------------------
  // Data types
  // ----------------------------------------

  // One cipher block, byte 0 sits in bits 127:120
  typedef union packed {
    logic [BlkLen-1:0]  flat;
    logic [0:15][7:0]   bytes;
  } blk_u;

  typedef struct packed {
    logic [CmdLen-1:0] cmd;
    logic [IdLen-1:0]  id;
  } tag_t;

  typedef struct packed {
    logic [KeyLen-1:0] key;
    blk_u              v;
    tag_t              tag;
  } blkenc_req_t;

  // ----------------------------------------
  // AES helpers
  // ----------------------------------------

  // Forward S-box, entry 0 in the top byte
  localparam logic [2047:0] SBoxTable = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic logic [7:0] aes_sbox(input logic [7:0] b);
    return SBoxTable[8 * (255 - int'(b)) +: 8];
  endfunction

  // Multiply by x in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

// File: rtl/blkenc_req_capture.sv
// Request capture register holding one accepted request for the cipher core
`timescale 1ns/1ps

module blkenc_req_capture (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          enable_i,
  input  logic                          req_i,
  input  logic [blkenc_pkg::KeyLen-1:0] key_i,
  input  logic [blkenc_pkg::BlkLen-1:0] v_i,
  input  blkenc_pkg::tag_t              tag_i,
  output logic                          rdy_o,
  input  logic                          core_idle_i,
  output logic                          cap_valid_o,
  output blkenc_pkg::blkenc_req_t       cap_req_o
);
  import blkenc_pkg::*;

  logic        valid_q;
  logic        accept;
  logic        take;
  blkenc_req_t req_q;

  // Room for a new request only while the holding slot is empty
  assign rdy_o  = enable_i & ~valid_q;
  assign accept = req_i & rdy_o;
  assign take   = cap_valid_o & core_idle_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (!enable_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (take) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.key    <= key_i;
      req_q.v.flat <= v_i;
      req_q.tag    <= tag_i;
    end
  end

  assign cap_valid_o = enable_i & valid_q;
  assign cap_req_o   = req_q;

endmodule

// File: rtl/aes_key_sched.sv
// AES-256 key expansion that produces one round key per step on the fly
`timescale 1ns/1ps

module aes_key_sched (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          load_i,
  input  logic                          step_i,
  input  logic [blkenc_pkg::KeyLen-1:0] key_i,
  output blkenc_pkg::blk_u              rkey_o
);
  import blkenc_pkg::*;

  // hi_q is the older half, lo_q the round key for the next round
  logic [BlkLen-1:0] hi_q;
  logic [BlkLen-1:0] lo_q;
  logic [BlkLen-1:0] next_half;
  logic [7:0]        rcon_q;
  logic              rot_phase_q;
  logic [31:0]       rot_w;
  logic [31:0]       sub_w;
  logic [31:0]       temp_w;

  // ----------------------------------------
  // Next half from the last word of lo_q
  // ----------------------------------------
  always_comb begin
    rot_w = rot_phase_q ? {lo_q[23:0], lo_q[31:24]} : lo_q[31:0];
    for (int i = 0; i < 4; i++) begin
      sub_w[8*i +: 8] = aes_sbox(rot_w[8*i +: 8]);
    end
    temp_w = sub_w ^ (rot_phase_q ? {rcon_q, 24'h000000} : 32'h0);
    next_half[127:96] = hi_q[127:96] ^ temp_w;
    next_half[95:64]  = hi_q[95:64] ^ next_half[127:96];
    next_half[63:32]  = hi_q[63:32] ^ next_half[95:64];
    next_half[31:0]   = hi_q[31:0] ^ next_half[63:32];
  end

  // Rcon and the RotWord phase alternate every step
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rcon_q      <= 8'h01;
      rot_phase_q <= 1'b1;
    end else if (load_i) begin
      rcon_q      <= 8'h01;
      rot_phase_q <= 1'b1;
    end else if (step_i) begin
      if (rot_phase_q) begin
        rcon_q <= xtime(rcon_q);
      end
      rot_phase_q <= ~rot_phase_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      hi_q <= key_i[KeyLen-1 -: BlkLen];
      lo_q <= key_i[BlkLen-1:0];
    end else if (step_i) begin
      hi_q <= lo_q;
      lo_q <= next_half;
    end
  end

  assign rkey_o.flat = lo_q;

endmodule

// File: rtl/aes_round.sv
// One AES encryption round as combinational logic
`timescale 1ns/1ps

module aes_round (
  input  blkenc_pkg::blk_u state_i,
  input  blkenc_pkg::blk_u rkey_i,
  input  logic             last_i,
  output blkenc_pkg::blk_u state_o
);
  import blkenc_pkg::*;

  blk_u sub_s;
  blk_u shift_s;
  blk_u mix_s;

  // SubBytes
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      sub_s.bytes[i] = aes_sbox(state_i.bytes[i]);
    end
  end

  // ShiftRows, row r rotates left by r columns
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift_s.bytes[4*c + r] = sub_s.bytes[4*((c + r) % 4) + r];
      end
    end
  end

  // MixColumns
  always_comb begin
    logic [7:0] a0, a1, a2, a3;
    for (int c = 0; c < 4; c++) begin
      a0 = shift_s.bytes[4*c];
      a1 = shift_s.bytes[4*c + 1];
      a2 = shift_s.bytes[4*c + 2];
      a3 = shift_s.bytes[4*c + 3];
      mix_s.bytes[4*c]     = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
      mix_s.bytes[4*c + 1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
      mix_s.bytes[4*c + 2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
      mix_s.bytes[4*c + 3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    end
  end

  // Final round skips MixColumns
  assign state_o.flat = (last_i ? shift_s.flat : mix_s.flat) ^ rkey_i.flat;

endmodule

// File: rtl/aes256_cipher_core.sv
// Iterative AES-256 forward cipher running one round per clock
`timescale 1ns/1ps

module aes256_cipher_core (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    enable_i,
  input  logic                    start_i,
  input  blkenc_pkg::blkenc_req_t req_i,
  output logic                    idle_o,
  output logic                    res_valid_o,
  output blkenc_pkg::blk_u        res_o,
  input  logic                    pop_i,
  output logic                    err_o
);
  import blkenc_pkg::*;

  typedef enum logic [1:0] {
    StIdle  = 2'b00,
    StRound = 2'b01,
    StHold  = 2'b10
  } core_st_e;

  core_st_e   fsm_q, fsm_d;
  logic [3:0] rnd_q, rnd_d;
  blk_u       state_q;
  blk_u       round_out;
  blk_u       rkey;
  logic       launch;
  logic       load;
  logic       step;
  logic       last_rnd;
  logic       fsm_err;

  // Free again in the cycle the held result leaves
  assign idle_o      = enable_i & ((fsm_q == StIdle) | ((fsm_q == StHold) & pop_i));
  assign launch      = start_i & idle_o;
  assign res_valid_o = enable_i & (fsm_q == StHold);
  assign last_rnd    = (rnd_q == 4'(NumRounds));

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_comb begin
    fsm_d   = fsm_q;
    rnd_d   = rnd_q;
    load    = 1'b0;
    step    = 1'b0;
    fsm_err = 1'b0;
    case (fsm_q)
      StIdle: ;
      StRound: begin
        step = 1'b1;
        if (last_rnd) begin
          fsm_d = StHold;
          rnd_d = '0;
        end else begin
          rnd_d = rnd_q + 4'd1;
        end
      end
      StHold: if (pop_i) fsm_d = StIdle;
      default: begin
        fsm_d   = StIdle;
        rnd_d   = '0;
        fsm_err = 1'b1;
      end
    endcase
    // Back to back start straight from hold
    if (launch) begin
      fsm_d = StRound;
      rnd_d = 4'd1;
      load  = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fsm_q <= StIdle;
      rnd_q <= '0;
    end else if (!enable_i) begin
      fsm_q <= StIdle;
      rnd_q <= '0;
    end else begin
      fsm_q <= fsm_d;
      rnd_q <= rnd_d;
    end
  end

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  // Load applies round key 0, the upper key half
  always_ff @(posedge clk_i) begin
    if (load) begin
      state_q.flat <= req_i.v.flat ^ req_i.key[KeyLen-1 -: BlkLen];
    end else if (step) begin
      state_q <= round_out;
    end
  end

  aes_key_sched u_key_sched (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .load_i   (load),
    .step_i   (step),
    .key_i    (req_i.key),
    .rkey_o   (rkey)
  );

  aes_round u_round (
    .state_i (state_q),
    .rkey_i  (rkey),
    .last_i  (last_rnd),
    .state_o (round_out)
  );

  assign res_o = state_q;
  assign err_o = enable_i & (fsm_err | (rnd_q > 4'(NumRounds)));

endmodule

// File: rtl/blkenc_resp_stage.sv
// Response stage pairing cipher results with queued command and id tags
`timescale 1ns/1ps

module blkenc_resp_stage (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          enable_i,
  input  logic                          tag_push_i,
  input  blkenc_pkg::tag_t              tag_i,
  input  logic                          res_valid_i,
  input  blkenc_pkg::blk_u              res_i,
  input  logic                          rdy_i,
  output logic                          pop_o,
  output logic                          valid_o,
  output logic [blkenc_pkg::BlkLen-1:0] v_o,
  output blkenc_pkg::tag_t              tag_o,
  output logic                          ack_o,
  output logic [2:0]                    fifo_err_o,
  output logic                          tag_pending_o
);
  import blkenc_pkg::*;

  tag_t               tag_mem [TagFifoDepth];
  logic [TagPtrW-1:0] wptr_q;
  logic [TagPtrW-1:0] rptr_q;
  logic [TagCntW-1:0] cnt_q;
  logic               full;
  logic               empty;
  logic               do_push;
  logic               do_pop;

  assign full    = (cnt_q == TagCntW'(TagFifoDepth));
  assign empty   = (cnt_q == '0);
  assign do_push = tag_push_i & ~full;
  assign do_pop  = pop_o & ~empty;

  // ----------------------------------------
  // Tag FIFO
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else if (!enable_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == TagPtrW'(TagFifoDepth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == TagPtrW'(TagFifoDepth - 1)) ? '0 : rptr_q + 1'b1;
      end
      cnt_q <= cnt_q + TagCntW'(do_push) - TagCntW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      tag_mem[wptr_q] <= tag_i;
    end
  end

  // ----------------------------------------
  // Result handshake
  // ----------------------------------------
  assign valid_o = res_valid_i;
  assign ack_o   = valid_o & rdy_i;
  assign pop_o   = ack_o;
  assign v_o     = res_i.flat;
  assign tag_o   = tag_mem[rptr_q];

  assign tag_pending_o = enable_i & ~empty;

  // Push while full, pop while empty, count out of step with the pointers
  assign fifo_err_o = {3{enable_i}} & {(tag_push_i & full),
                                       (pop_o & empty),
                                       ((cnt_q > TagCntW'(TagFifoDepth)) |
                                        (empty & (wptr_q != rptr_q)))};

endmodule

// File: rtl/blkenc_top.sv
// Block encrypt top level joining request capture, AES-256 core and response stage
`timescale 1ns/1ps

module blkenc_top (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          enable_i,
  input  logic                          req_i,
  output logic                          rdy_o,
  input  logic [blkenc_pkg::KeyLen-1:0] key_i,
  input  logic [blkenc_pkg::BlkLen-1:0] v_i,
  input  blkenc_pkg::tag_t              tag_i,
  output logic                          valid_o,
  output logic [blkenc_pkg::BlkLen-1:0] v_o,
  output blkenc_pkg::tag_t              tag_o,
  output logic                          ack_o,
  input  logic                          rdy_i,
  output logic                          quiet_o,
  output logic                          err_o,
  output logic [2:0]                    fifo_err_o
);
  import blkenc_pkg::*;

  logic        cap_valid;
  blkenc_req_t cap_req;
  logic        core_idle;
  logic        tag_push;
  logic        res_valid;
  blk_u        res;
  logic        res_pop;
  logic        tag_pending;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  blkenc_req_capture u_capture (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .enable_i    (enable_i),
    .req_i       (req_i),
    .key_i       (key_i),
    .v_i         (v_i),
    .tag_i       (tag_i),
    .rdy_o       (rdy_o),
    .core_idle_i (core_idle),
    .cap_valid_o (cap_valid),
    .cap_req_o   (cap_req)
  );

  // Tag enters the FIFO on the edge the core takes the request
  assign tag_push = cap_valid & core_idle;

  aes256_cipher_core u_core (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .enable_i    (enable_i),
    .start_i     (cap_valid),
    .req_i       (cap_req),
    .idle_o      (core_idle),
    .res_valid_o (res_valid),
    .res_o       (res),
    .pop_i       (res_pop),
    .err_o       (err_o)
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  blkenc_resp_stage u_resp (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .enable_i      (enable_i),
    .tag_push_i    (tag_push),
    .tag_i         (cap_req.tag),
    .res_valid_i   (res_valid),
    .res_i         (res),
    .rdy_i         (rdy_i),
    .pop_o         (res_pop),
    .valid_o       (valid_o),
    .v_o           (v_o),
    .tag_o         (tag_o),
    .ack_o         (ack_o),
    .fifo_err_o    (fifo_err_o),
    .tag_pending_o (tag_pending)
  );

  // Nothing waiting in capture and no tag outstanding
  assign quiet_o = ~(cap_valid | tag_pending);

endmodule

// File: testbench/tb_blkenc.sv
// Self-checking testbench for the block encrypt stage driven from a stimulus file
`timescale 1ns/1ps

module tb_blkenc;
  import blkenc_pkg::*;

  localparam int AcceptToValid = 16;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  enable_i;
  logic                  req_i;
  logic                  rdy_o;
  logic [KeyLen-1:0]     key_i;
  logic [BlkLen-1:0]     v_i;
  tag_t                  tag_i;
  logic                  valid_o;
  logic [BlkLen-1:0]     v_o;
  tag_t                  tag_o;
  logic                  ack_o;
  logic                  rdy_i;
  logic                  quiet_o;
  logic                  err_o;
  logic [2:0]            fifo_err_o;

  // Vectors from the stimulus file
  logic [KeyLen-1:0] vec_key[$];
  blk_u              vec_v[$];
  tag_t              vec_tag[$];
  blk_u              vec_ct[$];
  int                vec_stall[$];

  // Scoreboard with one entry per accepted request
  blk_u exp_blk_q[$];
  tag_t exp_tag_q[$];
  int   exp_stall_q[$];

  int          cyc = 0;
  int          cyc_limit = 0;
  int          cur_vec = 0;
  int          accept_count = 0;
  int          ack_count = 0;
  int          flushed = 0;
  int          max_inflight = 0;
  int          lat_start = 0;
  logic        lat_armed = 1'b0;
  logic        saw_accept;
  logic        saw_valid;
  logic        saw_ack;
  int          head_stall;
  logic [31:0] rng = 32'h6a635c53;

  blkenc_top uut (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .enable_i   (enable_i),
    .req_i      (req_i),
    .rdy_o      (rdy_o),
    .key_i      (key_i),
    .v_i        (v_i),
    .tag_i      (tag_i),
    .valid_o    (valid_o),
    .v_o        (v_o),
    .tag_o      (tag_o),
    .ack_o      (ack_o),
    .rdy_i      (rdy_i),
    .quiet_o    (quiet_o),
    .err_o      (err_o),
    .fifo_err_o (fifo_err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_on_failure();
    $display("Regression failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_blk(input string name, input blk_u expv, input blk_u actv);
    if (actv !== expv) begin
      $display("ERR t=%0t %s expected %h actual %h", $time, name, expv.flat, actv.flat);
      stop_on_failure();
    end
  endtask

  task automatic check_tag(input string name, input tag_t expv, input tag_t actv);
    if (actv !== expv) begin
      $display("ERR t=%0t %s expected cmd %0d id %0d actual cmd %0d id %0d", $time, name,
               expv.cmd, expv.id, actv.cmd, actv.id);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic expv, input logic actv);
    if (actv !== expv) begin
      $display("ERR t=%0t %s expected %b actual %b", $time, name, expv, actv);
      stop_on_failure();
    end
  endtask

  task automatic load_vectors();
    int                fd;
    int                code;
    int                num;
    int                stall;
    string             line;
    logic [KeyLen-1:0] key;
    logic [BlkLen-1:0] v;
    logic [BlkLen-1:0] ct;
    logic [CmdLen-1:0] cmd;
    logic [IdLen-1:0]  id;
    blk_u              b;
    tag_t              tag;
    fd = $fopen("testbench/blkenc_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file testbench/blkenc_stim.txt");
      stop_on_failure();
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 1 && line[0] != "#") begin
          code = $sscanf(line, "%d %h %h %h %h %h %d", num, key, v, cmd, id, ct, stall);
          if (code != 7 || num != vec_ct.size()) begin
            $display("Malformed stimulus line after vector %0d", vec_ct.size());
            stop_on_failure();
          end else begin
            vec_key.push_back(key);
            b.flat = v;
            vec_v.push_back(b);
            tag.cmd = cmd;
            tag.id  = id;
            vec_tag.push_back(tag);
            b.flat = ct;
            vec_ct.push_back(b);
            vec_stall.push_back(stall);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_vector(input int i);
    cur_vec = i;
    req_i   = 1'b1;
    key_i   = vec_key[i];
    v_i     = vec_v[i].flat;
    tag_i   = vec_tag[i];
  endtask

  // ----------------------------------------
  // Per-cycle monitor sampled at the falling edge
  // ----------------------------------------
  task automatic observe();
    blk_u got;
    logic exp_ack;
    got.flat   = v_o;
    saw_accept = 1'b0;
    saw_ack    = 1'b0;
    saw_valid  = valid_o;
    // Disable clears every stage at the coming edge
    if (!enable_i) begin
      flushed += exp_blk_q.size();
      exp_blk_q.delete();
      exp_tag_q.delete();
      exp_stall_q.delete();
      lat_armed = 1'b0;
    end
    // The consumer raises rdy_i only while the head result is held
    exp_ack = rdy_i & (exp_blk_q.size() != 0);
    check_bit("err_o", 1'b0, err_o);
    check_bit("fifo_err_o[0]", 1'b0, fifo_err_o[0]);
    check_bit("fifo_err_o[1]", 1'b0, fifo_err_o[1]);
    check_bit("fifo_err_o[2]", 1'b0, fifo_err_o[2]);
    check_bit("ack_o", exp_ack, ack_o);
    check_bit("quiet_o", exp_blk_q.size() == 0, quiet_o);
    if (exp_blk_q.size() == 0) begin
      check_bit("rdy_o", enable_i, rdy_o);
      check_bit("valid_o", 1'b0, valid_o);
    end
    if (exp_blk_q.size() == TagFifoDepth) begin
      check_bit("rdy_o", 1'b0, rdy_o);
    end
    if (exp_ack) begin
      check_bit("valid_o", 1'b1, valid_o);
    end
    if (valid_o) begin
      check_blk("v_o", exp_blk_q[0], got);
      check_tag("tag_o", exp_tag_q[0], tag_o);
      head_stall = exp_stall_q[0];
      if (lat_armed && (cyc - lat_start != AcceptToValid)) begin
        $display("ERR t=%0t valid_o latency expected %0d actual %0d", $time,
                 AcceptToValid, cyc - lat_start);
        stop_on_failure();
      end
      lat_armed = 1'b0;
    end
    if (exp_ack) begin
      void'(exp_blk_q.pop_front());
      void'(exp_tag_q.pop_front());
      void'(exp_stall_q.pop_front());
      ack_count++;
      saw_ack = 1'b1;
    end
    if (req_i && rdy_o) begin
      if (exp_blk_q.size() == 0) begin
        lat_armed = 1'b1;
        lat_start = cyc;
      end
      exp_blk_q.push_back(vec_ct[cur_vec]);
      exp_tag_q.push_back(vec_tag[cur_vec]);
      exp_stall_q.push_back(vec_stall[cur_vec]);
      if (exp_blk_q.size() > max_inflight) begin
        max_inflight = exp_blk_q.size();
      end
      accept_count++;
      saw_accept = 1'b1;
    end
  endtask

  // Check at the falling edge and drive 1 ns after the rising edge
  task automatic tick();
    @(negedge clk_i);
    observe();
    @(posedge clk_i);
    #1;
  endtask

  // Producer and consumer for vectors lo..hi with rdy_i stalls
  task automatic run_stream(input int lo, input int hi);
    int   p;
    int   target;
    int   stall_left;
    logic stall_set;
    p          = lo;
    target     = ack_count + hi - lo + 1;
    stall_left = 0;
    stall_set  = 1'b0;
    drive_vector(p);
    while (ack_count < target) begin
      tick();
      if (saw_accept) begin
        p++;
        if (p <= hi) begin
          drive_vector(p);
        end else begin
          req_i = 1'b0;
        end
      end
      if (saw_ack) begin
        rdy_i     = 1'b0;
        stall_set = 1'b0;
      end else if (saw_valid) begin
        if (!stall_set) begin
          stall_left = head_stall + int'(rng % 32'd3);
          rng        = xorshift32(rng);
          stall_set  = 1'b1;
        end
        if (stall_left == 0) begin
          rdy_i = 1'b1;
        end else begin
          stall_left--;
        end
      end
    end
    req_i = 1'b0;
    rdy_i = 1'b0;
  endtask

  // Two requests in flight and then a one-cycle disable mid-operation
  task automatic enable_drop();
    drive_vector(0);
    do tick(); while (!saw_accept);
    drive_vector(1);
    do tick(); while (!saw_accept);
    req_i = 1'b0;
    repeat (6) tick();
    enable_i = 1'b0;
    tick();
    enable_i = 1'b1;
    tick();
    run_stream(2, 2);
  endtask

  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (cyc_limit > 0 && cyc > cyc_limit) begin
      $display("Timeout after %0d cycles without finishing the run", cyc_limit);
      stop_on_failure();
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    arst_n_i = 1'b0;
    enable_i = 1'b0;
    req_i    = 1'b0;
    rdy_i    = 1'b0;
    key_i    = '0;
    v_i      = '0;
    tag_i    = '0;
    load_vectors();
    cyc_limit = 40 * (2 * vec_ct.size() + 3) + 100;
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    tick();
    enable_i = 1'b1;
    tick();
    // One request at a time so every accept sees an idle pipeline
    for (int i = 0; i < vec_ct.size(); i++) begin
      run_stream(i, i);
    end
    // Streamed with back-pressure
    run_stream(0, vec_ct.size() - 1);
    enable_drop();
    repeat (2) tick();
    if (exp_blk_q.size() == 0 && max_inflight == TagFifoDepth) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Bookkeeping mismatch: %0d accepted, %0d acked, %0d flushed, max %0d in flight",
               accept_count, ack_count, flushed, max_inflight);
      stop_on_failure();
    end
  end

endmodule

// File: testbench/blkenc_stim.txt
# num key v cmd id expected_ciphertext stall (hex fields, num and stall decimal)
# stall is the number of cycles rdy_i stays low after valid_o rises
0 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f 00112233445566778899aabbccddeeff 1 3 8ea2b7ca516745bfeafc49904b496089 0
1 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 6bc1bee22e409f96e93d7e117393172a 2 5 f3eed1bdb5d2a03c064b5a7e3db181f8 4
2 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 ae2d8a571e03ac9c9eb76fac45af8e51 3 7 591ccb10d410ed26dc5ba74a31362870 8
3 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 30c81c46a35ce411e5fbc1191a0a52ef 4 9 b6ed21b99ca6f4f9f153e7b1beafed1d 1
4 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 f69f2445df4f9b17ad2b417be66c3710 5 b 23304b7a39f9f3ff067d8d8f9e24ecc7 6
5 0000000000000000000000000000000000000000000000000000000000000000 00000000000000000000000000000000 6 0 dc95c078a2408989ad48a21492842087 2
6 0000000000000000000000000000000000000000000000000000000000000000 014730f80ac625fe84f026c60bfd547d 7 1 5c9d844ed46f9885085e5d6a4f94c7d7 0
7 0000000000000000000000000000000000000000000000000000000000000000 0b24af36193ce4665f2825d7b4749c98 0 2 a9ff75bd7cf6613d3731c77c3b6d0c04 7
8 0000000000000000000000000000000000000000000000000000000000000000 761c1fe41a18acf20d241650611d90f1 1 4 623a52fcea5d443e48d9181ab32c7421 3
9 0000000000000000000000000000000000000000000000000000000000000000 8a560769d605868ad80d819bdba03771 2 6 38f2c7ae10612415d27ca190d27da8b4 5
10 c47b0294dbbbee0fec4757f22ffeee3587ca4730c3d33b691df38bab076bc558 00000000000000000000000000000000 3 8 46f2fb342d6f0ab477476fc501242c5f 0
11 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f 00112233445566778899aabbccddeeff 7 f 8ea2b7ca516745bfeafc49904b496089 8
12 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 6bc1bee22e409f96e93d7e117393172a 0 a f3eed1bdb5d2a03c064b5a7e3db181f8 2
13 0000000000000000000000000000000000000000000000000000000000000000 00000000000000000000000000000000 5 c dc95c078a2408989ad48a21492842087 3
14 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f 00112233445566778899aabbccddeeff 6 d 8ea2b7ca516745bfeafc49904b496089 5
15 0000000000000000000000000000000000000000000000000000000000000000 014730f80ac625fe84f026c60bfd547d 3 e 5c9d844ed46f9885085e5d6a4f94c7d7 1

// File: files.f
rtl/blkenc_pkg.sv
rtl/blkenc_req_capture.sv
rtl/aes_key_sched.sv
rtl/aes_round.sv
rtl/aes256_cipher_core.sv
rtl/blkenc_resp_stage.sv
rtl/blkenc_top.sv
testbench/tb_blkenc.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_blkenc -f files.f -o Vtb_blkenc
	./obj_dir/Vtb_blkenc

clean:
	rm -rf obj_dir
